/* panel_defines.svh */
`ifndef PANEL_DEFINES_SVH
`define PANEL_DEFINES_SVH

// one knob reading from the ADC side
`define PANEL_KNOB_W 10
// patch routing source index
`define PANEL_SRC_W 3

// flops between the knob domain and clk_dram_ctrl
`define PANEL_SYNC_STAGES 2

// memory request completions seen since reset
`define PANEL_COUNT_W 24

// two four-digit displays
`define PANEL_DIGITS 8
// short dwell for simulation, raise for the board
`define PANEL_DIGIT_CYCLES 16

`endif

/* panel_pkg.sv */
`include "panel_defines.svh"

package panel_pkg;

    // synchronized knob value
    typedef logic [`PANEL_KNOB_W-1:0] knob_value_t;

    // which effect feeds a stage
    typedef logic [`PANEL_SRC_W-1:0] route_src_t;

    // eight hex nibbles, digit 0 in bits 3:0
    typedef logic [31:0] panel_word_t;

    // display page
    typedef logic [2:0] page_sel_t;

    // cathodes, active low, segment a in bit 0
    typedef logic [6:0] segments_t;

    // one group of four anodes, active low
    typedef logic [3:0] anodes_t;

    typedef enum logic {
        SCAN_BLANK, // all anodes off between digits
        SCAN_DRIVE  // one anode on
    } scan_phase_t;

endpackage

/* panel_status_top.sv */
`timescale 1ns/100ps
`include "panel_defines.svh"

module panel_status_top (
    input  logic                     clk_dram_ctrl,
    input  logic                     rst_dram_ctrl,
    input  panel_pkg::page_sel_t     i_page,
    input  logic                     i_memrequest_complete,
    input  panel_pkg::knob_value_t   i_volume,
    input  panel_pkg::knob_value_t   i_pitch,
    input  panel_pkg::knob_value_t   i_delay_wet,
    input  panel_pkg::knob_value_t   i_delay_rate,
    input  panel_pkg::knob_value_t   i_delay_feedback,
    input  panel_pkg::knob_value_t   i_reverb_wet,
    input  panel_pkg::knob_value_t   i_reverb_size,
    input  panel_pkg::knob_value_t   i_reverb_feedback,
    input  panel_pkg::knob_value_t   i_filter_quality,
    input  panel_pkg::knob_value_t   i_filter_cutoff,
    input  panel_pkg::knob_value_t   i_distortion_drive,
    input  panel_pkg::knob_value_t   i_crush_pressure,
    input  panel_pkg::route_src_t    i_output_src,
    input  panel_pkg::route_src_t    i_crush_src,
    input  panel_pkg::route_src_t    i_distortion_src,
    input  panel_pkg::route_src_t    i_filter_src,
    input  panel_pkg::route_src_t    i_reverb_src,
    input  panel_pkg::route_src_t    i_delay_src,
    output panel_pkg::anodes_t       o_ss0_an,
    output panel_pkg::anodes_t       o_ss1_an,
    output panel_pkg::segments_t     o_ss_c
);

    // knob values after the clock boundary
    panel_pkg::knob_value_t volume, pitch, delay_wet, delay_rate;
    panel_pkg::knob_value_t delay_feedback, reverb_wet, reverb_size, reverb_feedback;
    panel_pkg::knob_value_t filter_quality, filter_cutoff, distortion_drive, crush_pressure;
    panel_pkg::route_src_t  output_src, crush_src, distortion_src;
    panel_pkg::route_src_t  filter_src, reverb_src, delay_src;
    panel_pkg::panel_word_t display_word;

    param_sync i_param_sync (
        .clk_dram_ctrl, .rst_dram_ctrl,
        .i_volume, .i_pitch, .i_delay_wet, .i_delay_rate,
        .i_delay_feedback, .i_reverb_wet, .i_reverb_size, .i_reverb_feedback,
        .i_filter_quality, .i_filter_cutoff, .i_distortion_drive, .i_crush_pressure,
        .i_output_src, .i_crush_src, .i_distortion_src,
        .i_filter_src, .i_reverb_src, .i_delay_src,
        .o_volume(volume), .o_pitch(pitch),
        .o_delay_wet(delay_wet), .o_delay_rate(delay_rate),
        .o_delay_feedback(delay_feedback), .o_reverb_wet(reverb_wet),
        .o_reverb_size(reverb_size), .o_reverb_feedback(reverb_feedback),
        .o_filter_quality(filter_quality), .o_filter_cutoff(filter_cutoff),
        .o_distortion_drive(distortion_drive), .o_crush_pressure(crush_pressure),
        .o_output_src(output_src), .o_crush_src(crush_src),
        .o_distortion_src(distortion_src), .o_filter_src(filter_src),
        .o_reverb_src(reverb_src), .o_delay_src(delay_src)
    );

    status_page_select i_status_page_select (
        .clk_dram_ctrl, .rst_dram_ctrl,
        .i_page, .i_memrequest_complete,
        .i_volume(volume), .i_pitch(pitch),
        .i_delay_wet(delay_wet), .i_delay_rate(delay_rate),
        .i_delay_feedback(delay_feedback), .i_reverb_wet(reverb_wet),
        .i_reverb_size(reverb_size), .i_reverb_feedback(reverb_feedback),
        .i_filter_quality(filter_quality), .i_filter_cutoff(filter_cutoff),
        .i_distortion_drive(distortion_drive), .i_crush_pressure(crush_pressure),
        .i_output_src(output_src), .i_crush_src(crush_src),
        .i_distortion_src(distortion_src), .i_filter_src(filter_src),
        .i_reverb_src(reverb_src), .i_delay_src(delay_src),
        .o_display_word(display_word)
    );

    // both displays share one cathode bus
    segment_scanner i_segment_scanner (
        .clk_dram_ctrl, .rst_dram_ctrl,
        .i_display_word(display_word),
        .o_ss0_an, .o_ss1_an, .o_ss_c
    );

endmodule

/* param_sync.sv */
`timescale 1ns/100ps
`include "panel_defines.svh"

module param_sync (
    input  logic                     clk_dram_ctrl,
    input  logic                     rst_dram_ctrl,
    input  panel_pkg::knob_value_t   i_volume,
    input  panel_pkg::knob_value_t   i_pitch,
    input  panel_pkg::knob_value_t   i_delay_wet,
    input  panel_pkg::knob_value_t   i_delay_rate,
    input  panel_pkg::knob_value_t   i_delay_feedback,
    input  panel_pkg::knob_value_t   i_reverb_wet,
    input  panel_pkg::knob_value_t   i_reverb_size,
    input  panel_pkg::knob_value_t   i_reverb_feedback,
    input  panel_pkg::knob_value_t   i_filter_quality,
    input  panel_pkg::knob_value_t   i_filter_cutoff,
    input  panel_pkg::knob_value_t   i_distortion_drive,
    input  panel_pkg::knob_value_t   i_crush_pressure,
    input  panel_pkg::route_src_t    i_output_src,
    input  panel_pkg::route_src_t    i_crush_src,
    input  panel_pkg::route_src_t    i_distortion_src,
    input  panel_pkg::route_src_t    i_filter_src,
    input  panel_pkg::route_src_t    i_reverb_src,
    input  panel_pkg::route_src_t    i_delay_src,
    output panel_pkg::knob_value_t   o_volume,
    output panel_pkg::knob_value_t   o_pitch,
    output panel_pkg::knob_value_t   o_delay_wet,
    output panel_pkg::knob_value_t   o_delay_rate,
    output panel_pkg::knob_value_t   o_delay_feedback,
    output panel_pkg::knob_value_t   o_reverb_wet,
    output panel_pkg::knob_value_t   o_reverb_size,
    output panel_pkg::knob_value_t   o_reverb_feedback,
    output panel_pkg::knob_value_t   o_filter_quality,
    output panel_pkg::knob_value_t   o_filter_cutoff,
    output panel_pkg::knob_value_t   o_distortion_drive,
    output panel_pkg::knob_value_t   o_crush_pressure,
    output panel_pkg::route_src_t    o_output_src,
    output panel_pkg::route_src_t    o_crush_src,
    output panel_pkg::route_src_t    o_distortion_src,
    output panel_pkg::route_src_t    o_filter_src,
    output panel_pkg::route_src_t    o_reverb_src,
    output panel_pkg::route_src_t    o_delay_src
);

    localparam int STAGES = `PANEL_SYNC_STAGES;
    localparam int SYNC_W = 12 * `PANEL_KNOB_W + 6 * `PANEL_SRC_W;

    logic [SYNC_W-1:0] sync_in;
    logic [SYNC_W-1:0] chain_q [STAGES];
    logic [STAGES-1:0] fill_q; // one bit per clean shift since reset

    // every value rides the same chain, bit for bit
    assign sync_in = {i_volume, i_pitch, i_delay_wet, i_delay_rate,
                      i_delay_feedback, i_reverb_wet, i_reverb_size,
                      i_reverb_feedback, i_filter_quality, i_filter_cutoff,
                      i_distortion_drive, i_crush_pressure,
                      i_output_src, i_crush_src, i_distortion_src,
                      i_filter_src, i_reverb_src, i_delay_src};

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            for (int s = 0; s < STAGES; s++) begin
                chain_q[s] <= '0;
            end
            fill_q <= '0;
        end else begin
            chain_q[0] <= sync_in; // first flop may go metastable
            for (int s = 1; s < STAGES; s++) begin
                chain_q[s] <= chain_q[s-1];
            end
            fill_q <= (fill_q << 1) | 1'b1;
        end
    end

    assign {o_volume, o_pitch, o_delay_wet, o_delay_rate,
            o_delay_feedback, o_reverb_wet, o_reverb_size,
            o_reverb_feedback, o_filter_quality, o_filter_cutoff,
            o_distortion_drive, o_crush_pressure,
            o_output_src, o_crush_src, o_distortion_src,
            o_filter_src, o_reverb_src, o_delay_src} = chain_q[STAGES-1];

    // once the chain has refilled, the last stage is the input from STAGES edges back
    a_sync_delay: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        fill_q[STAGES-1] |-> (chain_q[STAGES-1] == $past(sync_in, STAGES)));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_panel_status -o tb_panel_status
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_panel_status > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* segment_scanner.sv */
`timescale 1ns/100ps
`include "panel_defines.svh"

module segment_scanner (
    input  logic                     clk_dram_ctrl,
    input  logic                     rst_dram_ctrl,
    input  panel_pkg::panel_word_t   i_display_word,
    output panel_pkg::anodes_t       o_ss0_an, // digits 4..7
    output panel_pkg::anodes_t       o_ss1_an, // digits 0..3
    output panel_pkg::segments_t     o_ss_c
);

    localparam int DIGITS = `PANEL_DIGITS;
    localparam int DIG_W  = $clog2(`PANEL_DIGITS);
    localparam int CYC_W  = $clog2(`PANEL_DIGIT_CYCLES);

    panel_pkg::scan_phase_t phase_q;
    logic [DIG_W-1:0]       digit_q;
    logic [CYC_W-1:0]       cycle_q;  // dwell within the current digit
    logic [3:0]             nibble;
    logic [DIGITS-1:0]      an_all;   // all eight anodes, digit 0 in bit 0

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            phase_q <= panel_pkg::SCAN_BLANK;
            digit_q <= '0;
            cycle_q <= '0;
        end else begin
            case (phase_q)
                panel_pkg::SCAN_BLANK: begin
                    phase_q <= panel_pkg::SCAN_DRIVE; // blank is a single cycle
                    cycle_q <= '0;
                end
                panel_pkg::SCAN_DRIVE: begin
                    if (cycle_q == CYC_W'(`PANEL_DIGIT_CYCLES - 1)) begin
                        phase_q <= panel_pkg::SCAN_BLANK;
                        if (digit_q == DIG_W'(DIGITS - 1)) begin
                            digit_q <= '0;
                        end else begin
                            digit_q <= digit_q + 1'b1;
                        end
                    end else begin
                        cycle_q <= cycle_q + 1'b1;
                    end
                end
                default: phase_q <= panel_pkg::SCAN_BLANK;
            endcase
        end
    end

    // live nibble, so a page change shows on the very next drive cycle
    assign nibble = i_display_word[digit_q * 4 +: 4];

    always_comb begin
        case (nibble)
            4'h0: o_ss_c = ~7'h3F;
            4'h1: o_ss_c = ~7'h06;
            4'h2: o_ss_c = ~7'h5B;
            4'h3: o_ss_c = ~7'h4F;
            4'h4: o_ss_c = ~7'h66;
            4'h5: o_ss_c = ~7'h6D;
            4'h6: o_ss_c = ~7'h7D;
            4'h7: o_ss_c = ~7'h07;
            4'h8: o_ss_c = ~7'h7F;
            4'h9: o_ss_c = ~7'h6F;
            4'hA: o_ss_c = ~7'h77;
            4'hB: o_ss_c = ~7'h7C; // lower case b
            4'hC: o_ss_c = ~7'h39;
            4'hD: o_ss_c = ~7'h5E; // lower case d
            4'hE: o_ss_c = ~7'h79;
            default: o_ss_c = ~7'h71;
        endcase
    end

    always_comb begin
        an_all = '1;
        if (phase_q == panel_pkg::SCAN_DRIVE) begin
            an_all[digit_q] = 1'b0;
        end
    end

    assign o_ss1_an = an_all[3:0];
    assign o_ss0_an = an_all[7:4];

    // the two groups share cathodes, so two lit digits would show the same glyph
    a_one_anode: assert property (@(posedge clk_dram_ctrl)
        $countones(~{o_ss0_an, o_ss1_an}) <= 1);

endmodule

/* sources.f */
+incdir+.
panel_pkg.sv
param_sync.sv
status_page_select.sv
segment_scanner.sv
panel_status_top.sv
tb_panel_status.sv

/* status_page_select.sv */
`timescale 1ns/100ps
`include "panel_defines.svh"

module status_page_select (
    input  logic                     clk_dram_ctrl,
    input  logic                     rst_dram_ctrl,
    input  panel_pkg::page_sel_t     i_page,
    input  logic                     i_memrequest_complete, // one-cycle pulse
    input  panel_pkg::knob_value_t   i_volume,
    input  panel_pkg::knob_value_t   i_pitch,
    input  panel_pkg::knob_value_t   i_delay_wet,
    input  panel_pkg::knob_value_t   i_delay_rate,
    input  panel_pkg::knob_value_t   i_delay_feedback,
    input  panel_pkg::knob_value_t   i_reverb_wet,
    input  panel_pkg::knob_value_t   i_reverb_size,
    input  panel_pkg::knob_value_t   i_reverb_feedback,
    input  panel_pkg::knob_value_t   i_filter_quality,
    input  panel_pkg::knob_value_t   i_filter_cutoff,
    input  panel_pkg::knob_value_t   i_distortion_drive,
    input  panel_pkg::knob_value_t   i_crush_pressure,
    input  panel_pkg::route_src_t    i_output_src,
    input  panel_pkg::route_src_t    i_crush_src,
    input  panel_pkg::route_src_t    i_distortion_src,
    input  panel_pkg::route_src_t    i_filter_src,
    input  panel_pkg::route_src_t    i_reverb_src,
    input  panel_pkg::route_src_t    i_delay_src,
    output panel_pkg::panel_word_t   o_display_word
);

    logic [`PANEL_COUNT_W-1:0] complete_count;

    // two knobs side by side, each padded to a 16-bit half
    function automatic panel_pkg::panel_word_t knob_pair(
        input panel_pkg::knob_value_t hi,
        input panel_pkg::knob_value_t lo
    );
        return {{(16 - `PANEL_KNOB_W){1'b0}}, hi, {(16 - `PANEL_KNOB_W){1'b0}}, lo};
    endfunction

    // a routing source padded out to one hex digit
    function automatic logic [3:0] src_nibble(input panel_pkg::route_src_t src);
        return {{(4 - `PANEL_SRC_W){1'b0}}, src};
    endfunction

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            complete_count <= '0;
        end else if (i_memrequest_complete) begin
            complete_count <= complete_count + 1'b1; // wraps
        end
    end

    always_comb begin
        case (i_page)
            3'd1: o_display_word = knob_pair(i_volume, i_pitch);
            3'd2: o_display_word = knob_pair(i_delay_wet, i_delay_rate);
            3'd3: o_display_word = knob_pair(i_delay_feedback, i_reverb_wet);
            3'd4: o_display_word = knob_pair(i_reverb_size, i_reverb_feedback);
            3'd5: o_display_word = knob_pair(i_filter_quality, i_filter_cutoff);
            3'd6: o_display_word = knob_pair(i_distortion_drive, i_crush_pressure);
            3'd7: begin
                // patch map, top byte left dark
                o_display_word = {8'h00,
                                  src_nibble(i_delay_src),
                                  src_nibble(i_reverb_src),
                                  src_nibble(i_filter_src),
                                  src_nibble(i_distortion_src),
                                  src_nibble(i_crush_src),
                                  src_nibble(i_output_src)};
            end
            default: o_display_word = {16'h0000, complete_count[15:0]}; // page 0
        endcase
    end

    // a pulse shows up as exactly one step, and nothing else moves the count
    a_count_step: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (!$past(rst_dram_ctrl) && $past(i_memrequest_complete))
            |-> (complete_count == $past(complete_count) + 1'b1));

    a_count_hold: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (!$past(rst_dram_ctrl) && !$past(i_memrequest_complete))
            |-> $stable(complete_count));

endmodule

/* tb_panel_status.sv */
`timescale 1ns/100ps
`include "panel_defines.svh"

module tb_panel_status;

    localparam int SYNC      = `PANEL_SYNC_STAGES;
    localparam int DWELL     = `PANEL_DIGIT_CYCLES;
    localparam int SCAN_LEN  = `PANEL_DIGITS * (DWELL + 1);
    localparam int RESET_CYC = 4;

    // lit segments abcdefg, a in bit 0, b and d lower case
    localparam logic [6:0] GLYPH [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic                   clk_dram_ctrl = 1'b0;
    logic                   rst_dram_ctrl;
    panel_pkg::page_sel_t   page;
    logic                   memrequest_complete;
    panel_pkg::knob_value_t knob [12]; // volume first, crush_pressure last
    panel_pkg::route_src_t  src [6];   // delay, reverb, filter, distortion, crush, output
    panel_pkg::anodes_t     ss0_an;
    panel_pkg::anodes_t     ss1_an;
    panel_pkg::segments_t   ss_c;

    // stimulus table
    string                  row_name [$];
    int                     row_page [$];
    panel_pkg::knob_value_t row_hi [$];
    panel_pkg::knob_value_t row_lo [$];
    int                     row_pulses [$];

    int pulse_total = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    always #2 clk_dram_ctrl = ~clk_dram_ctrl;

    panel_status_top i_panel_status_top (
        .clk_dram_ctrl(clk_dram_ctrl), .rst_dram_ctrl(rst_dram_ctrl),
        .i_page(page), .i_memrequest_complete(memrequest_complete),
        .i_volume(knob[0]), .i_pitch(knob[1]),
        .i_delay_wet(knob[2]), .i_delay_rate(knob[3]),
        .i_delay_feedback(knob[4]), .i_reverb_wet(knob[5]),
        .i_reverb_size(knob[6]), .i_reverb_feedback(knob[7]),
        .i_filter_quality(knob[8]), .i_filter_cutoff(knob[9]),
        .i_distortion_drive(knob[10]), .i_crush_pressure(knob[11]),
        .i_delay_src(src[0]), .i_reverb_src(src[1]), .i_filter_src(src[2]),
        .i_distortion_src(src[3]), .i_crush_src(src[4]), .i_output_src(src[5]),
        .o_ss0_an(ss0_an), .o_ss1_an(ss1_an), .o_ss_c(ss_c)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_segments(input string name, input panel_pkg::segments_t exp,
                                  input panel_pkg::segments_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_anodes(input string name,
                                input panel_pkg::anodes_t exp0, input panel_pkg::anodes_t exp1,
                                input panel_pkg::anodes_t act0, input panel_pkg::anodes_t act1);
        if ({act0, act1} !== {exp0, exp1}) begin
            fail_run($sformatf("MISMATCH %s: expected %h_%h, actual %h_%h",
                               name, exp0, exp1, act0, act1));
        end
    endtask

    task automatic add_row(input string name, input int pg, input panel_pkg::knob_value_t hi,
                           input panel_pkg::knob_value_t lo, input int pulses);
        row_name.push_back(name);
        row_page.push_back(pg);
        row_hi.push_back(hi);
        row_lo.push_back(lo);
        row_pulses.push_back(pulses);
        cycle_limit += SYNC + 2 * pulses + 4 * SCAN_LEN;
    endtask

    // word the display should carry for a page
    function automatic panel_pkg::panel_word_t expected_word(input int pg);
        panel_pkg::panel_word_t w;
        w = '0;
        if (pg == 0) begin
            w = 32'(pulse_total & 'hFFFF);
        end else if (pg == 7) begin
            for (int i = 0; i < 6; i++) begin
                w = w | (32'(src[i]) << (4 * (5 - i))); // delay on top
            end
        end else begin
            w = (32'(knob[2 * (pg - 1)]) << 16) | 32'(knob[2 * (pg - 1) + 1]);
        end
        return w;
    endfunction

    task automatic apply_row(input int r);
        for (int k = 0; k < 12; k++) begin
            knob[k] = panel_pkg::knob_value_t'($urandom);
        end
        for (int k = 0; k < 6; k++) begin
            src[k] = panel_pkg::route_src_t'($urandom);
        end
        if (row_page[r] >= 1 && row_page[r] <= 6) begin
            knob[2 * (row_page[r] - 1)]     = row_hi[r];
            knob[2 * (row_page[r] - 1) + 1] = row_lo[r];
        end
        page = panel_pkg::page_sel_t'(row_page[r]);
        repeat (row_pulses[r]) begin
            memrequest_complete = 1'b1;
            @(negedge clk_dram_ctrl);
            memrequest_complete = 1'b0; // gap cycle
            @(negedge clk_dram_ctrl);
            pulse_total++;
        end
        repeat (SYNC + 2 * SCAN_LEN) @(negedge clk_dram_ctrl);
    endtask

    // one scan, lined up on the first drive cycle of digit 0
    task automatic observe_scan(input int r);
        panel_pkg::panel_word_t exp_word;
        logic [7:0]             exp_an;
        bit                     was_blank;
        int                     digit;
        exp_word  = expected_word(row_page[r]);
        was_blank = 1'b0;
        while (!(was_blank && ss1_an == 4'b1110 && ss0_an == 4'b1111)) begin
            was_blank = (ss0_an == 4'hF && ss1_an == 4'hF);
            @(negedge clk_dram_ctrl);
        end
        for (int c = 0; c < SCAN_LEN; c++) begin
            digit  = c / (DWELL + 1);
            exp_an = 8'hFF;
            if (c % (DWELL + 1) < DWELL) begin
                exp_an[digit] = 1'b0;
            end
            check_anodes($sformatf("%s cycle %0d", row_name[r], c),
                         exp_an[7:4], exp_an[3:0], ss0_an, ss1_an);
            if (c % (DWELL + 1) < DWELL) begin
                check_segments($sformatf("%s digit %0d", row_name[r], digit),
                               ~GLYPH[exp_word[digit * 4 +: 4]], ss_c);
            end
            @(negedge clk_dram_ctrl);
        end
    endtask

    always @(posedge clk_dram_ctrl) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        rst_dram_ctrl       = 1'b1;
        page                = '0;
        memrequest_complete = 1'b0;
        for (int k = 0; k < 12; k++) begin
            knob[k] = '0;
        end
        for (int k = 0; k < 6; k++) begin
            src[k] = '0;
        end
        void'($urandom(98085));

        add_row("reset_zero",   0, 10'h000, 10'h000, 0);
        add_row("volume_pitch", 1, 10'h3FF, 10'h001, 3);
        add_row("delay_pair",   2, 10'h2A5, 10'h15A, 0);
        add_row("delay_reverb", 3, 10'h0BD, 10'h3C0, 2);
        add_row("reverb_pair",  4, 10'h246, 10'h09F, 0);
        add_row("filter_pair",  5, 10'h280, 10'h1FF, 5);
        add_row("drive_crush",  6, 10'h0ED, 10'h37B, 1);
        add_row("route_map",    7, 10'h000, 10'h000, 4);
        add_row("count_total",  0, 10'h000, 10'h000, 8);
        add_row("volume_zero",  1, 10'h000, 10'h000, 0);
        cycle_limit = 2 * (cycle_limit + RESET_CYC);

        repeat (RESET_CYC) begin
            @(negedge clk_dram_ctrl);
            check_anodes("reset", 4'hF, 4'hF, ss0_an, ss1_an); // dark while held
        end
        rst_dram_ctrl = 1'b0;

        for (int r = 0; r < row_name.size(); r++) begin
            apply_row(r);
            observe_scan(r);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule
